/* src/vl_consts.svh */
`ifndef VL_CONSTS_SVH
`define VL_CONSTS_SVH

// Word geometry
`define VL_DATA_W      32
`define VL_BYTES       4

// Register file depths
`define VL_VRF_DEPTH   64
`define VL_VMRF_DEPTH  32

// Read ports of the vector register file
`define VL_RD_PORTS    2

// Opcode width handed to the external ALU
`define VL_ALU_CTRL_W  6

// Pipeline depths in clock cycles
`define VL_MEM_DELAY   2
`define VL_WB_DELAY    2

`endif

/* src/vl_pkg.sv */
`include "vl_consts.svh"

package vl_pkg;

   // Data and byte enables
   typedef logic [`VL_DATA_W-1:0] word_t;
   typedef logic [`VL_BYTES-1:0]  bwen_t;

   // Addresses
   typedef logic [$clog2(`VL_VRF_DEPTH)-1:0]  vrf_addr_t;
   typedef logic [$clog2(`VL_VMRF_DEPTH)-1:0] vmrf_addr_t;

   // Byte position of an element inside a word
   typedef logic [$clog2(`VL_BYTES)-1:0] el_idx_t;

   // Opaque to the lane, only delayed
   typedef logic [`VL_ALU_CTRL_W-1:0] alu_ctrl_t;

   typedef enum logic [1:0] {
      SEW_8    = 2'b00,
      SEW_16   = 2'b01,
      SEW_32   = 2'b10,
      SEW_RSVD = 2'b11
   } sew_e;

   typedef enum logic {
      WB_ALU  = 1'b0,
      WB_LOAD = 1'b1
   } wb_src_e;

endpackage

/* src/vl_vrf_if.sv */
`timescale 1ns/1ps
`include "vl_consts.svh"

interface vl_vrf_if;

   // Read side, one entry per port
   logic [`VL_RD_PORTS-1:0]             ren;
   vl_pkg::vrf_addr_t [`VL_RD_PORTS-1:0] raddr;
   vl_pkg::word_t [`VL_RD_PORTS-1:0]     rdata;

   // Write side
   vl_pkg::vrf_addr_t waddr;
   vl_pkg::word_t     wdata;
   vl_pkg::bwen_t     bwen;

   modport rd_mp (output ren, output raddr, input rdata);

   modport wr_mp (output waddr, output wdata, output bwen);

   modport mem_mp (
      input  ren, input raddr, output rdata,
      input  waddr, input wdata, input bwen
   );

endinterface

/* src/vl_vrf.sv */
`timescale 1ns/1ps

module vl_vrf #(
   parameter int WIDTH    = 32,
   parameter int DEPTH    = 64,
   parameter int RD_PORTS = 2
) (
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic [RD_PORTS-1:0]                      ren_i,
   input  logic [RD_PORTS-1:0][$clog2(DEPTH)-1:0]   raddr_i,
   output logic [RD_PORTS-1:0][WIDTH-1:0]           rdata_o,
   input  logic [$clog2(DEPTH)-1:0]                 waddr_i,
   input  logic [WIDTH-1:0]                         wdata_i,
   input  logic [((WIDTH == 1) ? 1 : WIDTH/8)-1:0]  we_i
);

   // Byte lanes, or single bits for the mask file
   localparam int LANE_W = (WIDTH == 1) ? 1 : 8;
   localparam int BE_W   = WIDTH / LANE_W;

   logic [WIDTH-1:0] mem [DEPTH];

   logic [RD_PORTS-1:0]            ren_q;
   logic [RD_PORTS-1:0][WIDTH-1:0] mem_q;
   logic [RD_PORTS-1:0][WIDTH-1:0] rdata_q;

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < BE_W; b++) begin
         if (we_i[b]) begin
            mem[waddr_i][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
         end
      end
   end

   // RAM read register followed by an output register
   // A write landing on the read edge leaves the old word in the read register
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ren_q   <= '0;
         mem_q   <= '0;
         rdata_q <= '0;
      end else begin
         for (int p = 0; p < RD_PORTS; p++) begin
            ren_q[p] <= ren_i[p];
            if (ren_i[p]) begin
               mem_q[p] <= mem[raddr_i[p]];
            end
            if (ren_q[p]) begin
               rdata_q[p] <= mem_q[p];
            end
         end
      end
   end

   assign rdata_o = rdata_q;

   a_waddr_in_range : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      (|we_i) |-> (!$isunknown(waddr_i) && (int'(waddr_i) < DEPTH)));

endmodule

/* src/vl_operand_prep.sv */
`timescale 1ns/1ps
`include "vl_consts.svh"

module vl_operand_prep (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   vl_vrf_if.rd_mp                               vrf,
   input  logic [`VL_RD_PORTS-1:0]               rd_ren_i,
   input  vl_pkg::vrf_addr_t [`VL_RD_PORTS-1:0]  rd_addr_i,
   input  vl_pkg::el_idx_t [`VL_RD_PORTS-1:0]    el_idx_i,
   input  vl_pkg::sew_e                          vsew_i,
   input  vl_pkg::alu_ctrl_t                     alu_ctrl_i,
   input  logic                                  read_valid_i,
   output vl_pkg::word_t                         vs1_data_o,
   output vl_pkg::word_t                         vs2_data_o,
   output vl_pkg::alu_ctrl_t                     alu_opmode_o,
   output vl_pkg::sew_e                          alu_sew_o,
   output logic                                  alu_vld_o
);

   // Memory latency plus the preparation register
   localparam int CTRL_LAST = `VL_MEM_DELAY;
   localparam int EL_LAST   = `VL_MEM_DELAY - 1;

   typedef struct packed {
      vl_pkg::sew_e      sew;
      vl_pkg::alu_ctrl_t op;
      logic              vld;
   } ctrl_t;

   ctrl_t [CTRL_LAST:0]                                ctrl_q;
   vl_pkg::el_idx_t [EL_LAST:0][`VL_RD_PORTS-1:0]      el_q;

   logic [`VL_RD_PORTS-1:0][7:0]                       byte_c, byte_q;
   logic [`VL_RD_PORTS-1:0][15:0]                      hw_c, hw_q;
   vl_pkg::word_t [`VL_RD_PORTS-1:0]                   word_q;
   vl_pkg::word_t [`VL_RD_PORTS-1:0]                   operand;

   assign vrf.ren   = rd_ren_i;
   assign vrf.raddr = rd_addr_i;

   ////////////////////////////////////////////////////////////////////////////
   // Control and element index delay lines
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ctrl_q <= '0;
         el_q   <= '0;
      end else begin
         ctrl_q[0] <= '{sew: vsew_i, op: alu_ctrl_i, vld: read_valid_i};
         for (int i = 1; i <= CTRL_LAST; i++) begin
            ctrl_q[i] <= ctrl_q[i-1];
         end
         el_q[0] <= el_idx_i;
         for (int i = 1; i <= EL_LAST; i++) begin
            el_q[i] <= el_q[i-1];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Element extraction
   ////////////////////////////////////////////////////////////////////////////

   // Index arrives together with the raw word
   always_comb begin
      for (int p = 0; p < `VL_RD_PORTS; p++) begin
         byte_c[p] = vrf.rdata[p][el_q[EL_LAST][p]*8 +: 8];
         hw_c[p]   = vrf.rdata[p][el_q[EL_LAST][p][0]*16 +: 16];
      end
   end

   always_ff @(posedge clk_i) begin
      byte_q <= byte_c;
      hw_q   <= hw_c;
      word_q <= vrf.rdata;
   end

   // Final pick by the SEW that travelled with the request
   always_comb begin
      for (int p = 0; p < `VL_RD_PORTS; p++) begin
         case (ctrl_q[CTRL_LAST].sew)
            vl_pkg::SEW_8:  operand[p] = {{(`VL_DATA_W-8){1'b0}}, byte_q[p]};
            vl_pkg::SEW_16: operand[p] = {{(`VL_DATA_W-16){1'b0}}, hw_q[p]};
            vl_pkg::SEW_32: operand[p] = word_q[p];
            default:        operand[p] = '0;
         endcase
      end
   end

   assign vs1_data_o   = operand[0];
   assign vs2_data_o   = operand[1];
   assign alu_opmode_o = ctrl_q[CTRL_LAST].op;
   assign alu_sew_o    = ctrl_q[CTRL_LAST].sew;
   assign alu_vld_o    = ctrl_q[CTRL_LAST].vld;

   // A valid operand pair needs both ports read
   a_valid_reads_both : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      read_valid_i |-> (&rd_ren_i));

endmodule

/* src/vl_writeback.sv */
`timescale 1ns/1ps
`include "vl_consts.svh"

module vl_writeback (
   input  logic                clk_i,
   input  logic                rst_i,
   vl_vrf_if.wr_mp             vrf,
   input  logic                alu_vld_i,
   input  vl_pkg::word_t       alu_res_i,
   input  logic                alu_mask_i,
   input  logic                load_req_i,
   input  vl_pkg::word_t       load_data_i,
   input  vl_pkg::wb_src_e     wb_src_i,
   input  vl_pkg::vrf_addr_t   waddr_i,
   input  vl_pkg::bwen_t       bwen_i,
   input  logic                vector_mask_i,
   input  vl_pkg::vmrf_addr_t  vmrf_addr_i,
   input  logic                vmrf_wen_i,
   output vl_pkg::vmrf_addr_t  vmrf_raddr_o,
   input  logic                vmrf_rbit_i,
   output vl_pkg::vmrf_addr_t  vmrf_waddr_o,
   output logic                vmrf_wbit_o,
   output logic                vmrf_we_o
);

   localparam int LAST = `VL_WB_DELAY - 1;

   typedef struct packed {
      logic          valid;
      vl_pkg::bwen_t bwen;
      logic          vm;
      logic          vmrf_wen;
   } wb_ctl_t;

   typedef struct packed {
      vl_pkg::vrf_addr_t  waddr;
      vl_pkg::word_t      wdata;
      vl_pkg::vmrf_addr_t vmrf_addr;
      logic               vmrf_bit;
   } wb_dat_t;

   wb_ctl_t [LAST:0] ctl_q;
   wb_dat_t [LAST:0] dat_q;
   vl_pkg::word_t    wdata_sel;
   vl_pkg::bwen_t    bwen_out;

   assign wdata_sel = (wb_src_i == vl_pkg::WB_LOAD) ? load_data_i : alu_res_i;

   ////////////////////////////////////////////////////////////////////////////
   // Write pipeline
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ctl_q <= '0;
      end else begin
         ctl_q[0].valid    <= alu_vld_i | load_req_i;
         ctl_q[0].bwen     <= bwen_i;
         ctl_q[0].vm       <= vector_mask_i;
         ctl_q[0].vmrf_wen <= vmrf_wen_i;
         for (int i = 1; i <= LAST; i++) begin
            ctl_q[i] <= ctl_q[i-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      dat_q[0] <= '{waddr: waddr_i, wdata: wdata_sel,
                    vmrf_addr: vmrf_addr_i, vmrf_bit: alu_mask_i};
      for (int i = 1; i <= LAST; i++) begin
         dat_q[i] <= dat_q[i-1];
      end
   end

   // Mask bit is requested now and lands next to the last stage
   assign vmrf_raddr_o = vmrf_addr_i;

   ////////////////////////////////////////////////////////////////////////////
   // Byte enable gating and register file writes
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      bwen_out = ctl_q[LAST].bwen & {`VL_BYTES{ctl_q[LAST].valid}};
      if (ctl_q[LAST].vm) begin
         bwen_out = bwen_out & {`VL_BYTES{vmrf_rbit_i}};
      end
   end

   assign vrf.waddr = dat_q[LAST].waddr;
   assign vrf.wdata = dat_q[LAST].wdata;
   assign vrf.bwen  = bwen_out;

   assign vmrf_waddr_o = dat_q[LAST].vmrf_addr;
   assign vmrf_wbit_o  = dat_q[LAST].vmrf_bit;
   assign vmrf_we_o    = ctl_q[LAST].vmrf_wen & ctl_q[LAST].valid;

   // Load data must come with the load source selected
   a_load_selects_load : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      load_req_i |-> (wb_src_i == vl_pkg::WB_LOAD));

endmodule

/* src/vl_lane_top.sv */
`timescale 1ns/1ps
`include "vl_consts.svh"

module vl_lane_top (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   // Read request
   input  logic [`VL_RD_PORTS-1:0]               rd_ren_i,
   input  vl_pkg::vrf_addr_t [`VL_RD_PORTS-1:0]  rd_addr_i,
   input  vl_pkg::el_idx_t [`VL_RD_PORTS-1:0]    el_idx_i,
   input  vl_pkg::sew_e                          vsew_i,
   input  vl_pkg::alu_ctrl_t                     alu_ctrl_i,
   input  logic                                  read_valid_i,
   // Write-back
   input  logic                                  alu_vld_i,
   input  vl_pkg::word_t                         alu_res_i,
   input  logic                                  alu_mask_i,
   input  logic                                  load_req_i,
   input  vl_pkg::word_t                         load_data_i,
   input  vl_pkg::wb_src_e                       wb_src_i,
   input  vl_pkg::vrf_addr_t                     waddr_i,
   input  vl_pkg::bwen_t                         bwen_i,
   input  logic                                  vector_mask_i,
   input  vl_pkg::vmrf_addr_t                    vmrf_addr_i,
   input  logic                                  vmrf_wen_i,
   // Toward the ALU
   output vl_pkg::word_t                         vs1_data_o,
   output vl_pkg::word_t                         vs2_data_o,
   output vl_pkg::alu_ctrl_t                     alu_opmode_o,
   output vl_pkg::sew_e                          alu_sew_o,
   output logic                                  alu_vld_o
);

   vl_vrf_if vrf_bus ();

   vl_pkg::vmrf_addr_t vmrf_raddr;
   vl_pkg::vmrf_addr_t vmrf_waddr;
   logic               vmrf_rbit;
   logic               vmrf_wbit;
   logic               vmrf_we;

   ////////////////////////////////////////////////////////////////////////////
   // Register files
   ////////////////////////////////////////////////////////////////////////////

   vl_vrf #(
      .WIDTH    (`VL_DATA_W),
      .DEPTH    (`VL_VRF_DEPTH),
      .RD_PORTS (`VL_RD_PORTS)
   ) u_vrf (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ren_i   (vrf_bus.ren),
      .raddr_i (vrf_bus.raddr),
      .rdata_o (vrf_bus.rdata),
      .waddr_i (vrf_bus.waddr),
      .wdata_i (vrf_bus.wdata),
      .we_i    (vrf_bus.bwen)
   );

   // Mask file is read every cycle
   vl_vrf #(
      .WIDTH    (1),
      .DEPTH    (`VL_VMRF_DEPTH),
      .RD_PORTS (1)
   ) u_vmrf (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ren_i   (1'b1),
      .raddr_i (vmrf_raddr),
      .rdata_o (vmrf_rbit),
      .waddr_i (vmrf_waddr),
      .wdata_i (vmrf_wbit),
      .we_i    (vmrf_we)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Read and write paths
   ////////////////////////////////////////////////////////////////////////////

   vl_operand_prep u_operand_prep (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .vrf          (vrf_bus.rd_mp),
      .rd_ren_i     (rd_ren_i),
      .rd_addr_i    (rd_addr_i),
      .el_idx_i     (el_idx_i),
      .vsew_i       (vsew_i),
      .alu_ctrl_i   (alu_ctrl_i),
      .read_valid_i (read_valid_i),
      .vs1_data_o   (vs1_data_o),
      .vs2_data_o   (vs2_data_o),
      .alu_opmode_o (alu_opmode_o),
      .alu_sew_o    (alu_sew_o),
      .alu_vld_o    (alu_vld_o)
   );

   vl_writeback u_writeback (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .vrf           (vrf_bus.wr_mp),
      .alu_vld_i     (alu_vld_i),
      .alu_res_i     (alu_res_i),
      .alu_mask_i    (alu_mask_i),
      .load_req_i    (load_req_i),
      .load_data_i   (load_data_i),
      .wb_src_i      (wb_src_i),
      .waddr_i       (waddr_i),
      .bwen_i        (bwen_i),
      .vector_mask_i (vector_mask_i),
      .vmrf_addr_i   (vmrf_addr_i),
      .vmrf_wen_i    (vmrf_wen_i),
      .vmrf_raddr_o  (vmrf_raddr),
      .vmrf_rbit_i   (vmrf_rbit),
      .vmrf_waddr_o  (vmrf_waddr),
      .vmrf_wbit_o   (vmrf_wbit),
      .vmrf_we_o     (vmrf_we)
   );

endmodule

/* sim/vl_lane_tb.sv */
`timescale 1ns/1ps

module vl_lane_tb;

   localparam int CLK_PERIOD = 40;
   localparam int DRV_DLY    = 5;
   localparam int RST_CYCLES = 8;
   localparam int IDLE_GAP   = 3;
   localparam int VLD_WAIT   = 8;
   localparam int ROW_CYCLES = 12;
   // Cycles from the request drive edge to the first alu_vld_o cycle
   localparam int VLD_LAT    = 3;

   typedef enum logic [1:0] {K_LOAD, K_ALU, K_NONE, K_READ} kind_e;

   // One operation; write fields also steer the ALU reply of a read
   typedef struct packed {
      kind_e              kind;
      vl_pkg::vrf_addr_t  waddr;
      vl_pkg::bwen_t      bwen;
      vl_pkg::word_t      data;
      logic               vm;
      vl_pkg::vmrf_addr_t maddr;
      logic               mwen;
      logic               mbit;
      vl_pkg::vrf_addr_t  ra0;
      vl_pkg::vrf_addr_t  ra1;
      vl_pkg::el_idx_t    el0;
      vl_pkg::el_idx_t    el1;
      vl_pkg::sew_e       sew;
      vl_pkg::alu_ctrl_t  op;
      vl_pkg::word_t      exp1;
      vl_pkg::word_t      exp2;
   } row_t;

   logic                          clk_i;
   logic                          rst_i;
   logic [1:0]                    rd_ren_i;
   vl_pkg::vrf_addr_t [1:0]       rd_addr_i;
   vl_pkg::el_idx_t [1:0]         el_idx_i;
   vl_pkg::sew_e                  vsew_i;
   vl_pkg::alu_ctrl_t             alu_ctrl_i;
   logic                          read_valid_i;
   logic                          alu_vld_i;
   vl_pkg::word_t                 alu_res_i;
   logic                          alu_mask_i;
   logic                          load_req_i;
   vl_pkg::word_t                 load_data_i;
   vl_pkg::wb_src_e               wb_src_i;
   vl_pkg::vrf_addr_t             waddr_i;
   vl_pkg::bwen_t                 bwen_i;
   logic                          vector_mask_i;
   vl_pkg::vmrf_addr_t            vmrf_addr_i;
   logic                          vmrf_wen_i;
   vl_pkg::word_t                 vs1_data_o;
   vl_pkg::word_t                 vs2_data_o;
   vl_pkg::alu_ctrl_t             alu_opmode_o;
   vl_pkg::sew_e                  alu_sew_o;
   logic                          alu_vld_o;

   // Reference state of both register files
   vl_pkg::word_t ref_vrf [64];
   logic          ref_mask [32];
   row_t          rows [$];
   int            seed;
   int            err_cnt;
   int            wait_cnt;
   vl_pkg::word_t alu_sum;

   vl_lane_top u_vl_lane_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and table construction
   ////////////////////////////////////////////////////////////////////////////

   function automatic vl_pkg::word_t elem_of(input vl_pkg::word_t w,
                                             input vl_pkg::el_idx_t idx,
                                             input vl_pkg::sew_e sew);
      vl_pkg::word_t res;
      case (sew)
         vl_pkg::SEW_8:  res = (w >> (8 * idx)) & 32'h0000_00ff;
         vl_pkg::SEW_16: res = idx[0] ? (w >> 16) : (w & 32'h0000_ffff);
         vl_pkg::SEW_32: res = w;
         default:        res = '0;
      endcase
      return res;
   endfunction

   task automatic ref_write(input row_t r, input logic valid, input vl_pkg::word_t d);
      vl_pkg::bwen_t be;
      be = valid ? r.bwen : 4'h0;
      // Mask bit is read before this same write may update it
      if (r.vm && !ref_mask[r.maddr]) begin
         be = 4'h0;
      end
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            ref_vrf[r.waddr][8*b +: 8] = d[8*b +: 8];
         end
      end
      if (valid && r.mwen) begin
         ref_mask[r.maddr] = r.mbit;
      end
   endtask

   function automatic row_t wr_row(input kind_e k, input vl_pkg::vrf_addr_t wa,
                                   input vl_pkg::bwen_t be, input logic vm,
                                   input vl_pkg::vmrf_addr_t ma, input logic mwen,
                                   input logic mbit);
      row_t r;
      r       = '0;
      r.kind  = k;
      r.waddr = wa;
      r.bwen  = be;
      r.vm    = vm;
      r.maddr = ma;
      r.mwen  = mwen;
      r.mbit  = mbit;
      r.data  = $random(seed);
      return r;
   endfunction

   // Reply write disabled unless the caller sets byte enables
   function automatic row_t rd_row(input vl_pkg::vrf_addr_t a0, input vl_pkg::vrf_addr_t a1,
                                   input vl_pkg::el_idx_t e0, input vl_pkg::el_idx_t e1,
                                   input vl_pkg::sew_e sew);
      row_t r;
      r      = '0;
      r.kind = K_READ;
      r.ra0  = a0;
      r.ra1  = a1;
      r.el0  = e0;
      r.el1  = e1;
      r.sew  = sew;
      r.op   = $random(seed);
      return r;
   endfunction

   task automatic add_row(input row_t r);
      if (r.kind == K_READ) begin
         r.exp1 = elem_of(ref_vrf[r.ra0], r.el0, r.sew);
         r.exp2 = elem_of(ref_vrf[r.ra1], r.el1, r.sew);
         ref_write(r, 1'b1, r.exp1 + r.exp2);
      end else begin
         ref_write(r, r.kind != K_NONE, r.data);
      end
      rows.push_back(r);
   endtask

   task automatic build_table();
      row_t r;
      add_row(wr_row(K_LOAD, 3, 4'hf, 1'b0, 0, 1'b0, 1'b0));
      add_row(rd_row(3, 3, 0, 0, vl_pkg::SEW_32));
      add_row(wr_row(K_LOAD, 7, 4'hf, 1'b0, 0, 1'b0, 1'b0));
      for (int i = 0; i < 4; i++) begin
         add_row(rd_row(3, 7, vl_pkg::el_idx_t'(i), vl_pkg::el_idx_t'(3 - i), vl_pkg::SEW_8));
      end
      for (int i = 0; i < 4; i++) begin
         add_row(rd_row(7, 3, vl_pkg::el_idx_t'(i), vl_pkg::el_idx_t'(i + 1), vl_pkg::SEW_16));
      end
      add_row(rd_row(3, 7, 1, 2, vl_pkg::SEW_RSVD));
      // Partial write touches bytes 0 and 2
      add_row(wr_row(K_LOAD, 3, 4'b0101, 1'b0, 0, 1'b0, 1'b0));
      add_row(rd_row(3, 7, 0, 0, vl_pkg::SEW_32));
      // Mask bit 5 cleared, bit 6 set, then masked loads
      add_row(wr_row(K_ALU, 10, 4'hf, 1'b0, 5, 1'b1, 1'b0));
      add_row(wr_row(K_ALU, 11, 4'hf, 1'b0, 6, 1'b1, 1'b1));
      add_row(wr_row(K_LOAD, 3, 4'hf, 1'b1, 5, 1'b0, 1'b0));
      add_row(wr_row(K_LOAD, 7, 4'hf, 1'b1, 6, 1'b0, 1'b0));
      add_row(rd_row(3, 7, 0, 0, vl_pkg::SEW_32));
      add_row(wr_row(K_NONE, 7, 4'hf, 1'b0, 0, 1'b0, 1'b0));
      add_row(rd_row(10, 7, 0, 0, vl_pkg::SEW_32));
      // ALU round trip, then a reply blocked by mask bit 5
      r = rd_row(10, 11, 0, 0, vl_pkg::SEW_32);
      r.waddr = 20;
      r.bwen  = 4'hf;
      add_row(r);
      add_row(rd_row(20, 3, 0, 0, vl_pkg::SEW_32));
      r = rd_row(10, 11, 0, 0, vl_pkg::SEW_32);
      r.waddr = 3;
      r.bwen  = 4'hf;
      r.vm    = 1'b1;
      r.maddr = 5;
      add_row(r);
      add_row(rd_row(3, 20, 0, 0, vl_pkg::SEW_32));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Driving and checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic wait_drive_slot();
      @(posedge clk_i);
      #DRV_DLY;
   endtask

   task automatic clear_inputs();
      rd_ren_i      = '0;
      rd_addr_i     = '0;
      el_idx_i      = '0;
      vsew_i        = vl_pkg::SEW_8;
      alu_ctrl_i    = '0;
      read_valid_i  = 1'b0;
      alu_vld_i     = 1'b0;
      alu_res_i     = '0;
      alu_mask_i    = 1'b0;
      load_req_i    = 1'b0;
      load_data_i   = '0;
      wb_src_i      = vl_pkg::WB_ALU;
      waddr_i       = '0;
      bwen_i        = '0;
      vector_mask_i = 1'b0;
      vmrf_addr_i   = '0;
      vmrf_wen_i    = 1'b0;
   endtask

   task automatic drive_write_fields(input row_t r);
      waddr_i       = r.waddr;
      bwen_i        = r.bwen;
      vector_mask_i = r.vm;
      vmrf_addr_i   = r.maddr;
      vmrf_wen_i    = r.mwen;
      alu_mask_i    = r.mbit;
   endtask

   task automatic apply_row(input row_t r, input int idx);
      wait_drive_slot();
      if (r.kind == K_READ) begin
         rd_ren_i     = 2'b11;
         rd_addr_i[0] = r.ra0;
         rd_addr_i[1] = r.ra1;
         el_idx_i[0]  = r.el0;
         el_idx_i[1]  = r.el1;
         vsew_i       = r.sew;
         alu_ctrl_i   = r.op;
         read_valid_i = 1'b1;
         wait_drive_slot();
         clear_inputs();
         wait_cnt = 0;
         while (alu_vld_o !== 1'b1 && wait_cnt < VLD_WAIT) begin
            @(negedge clk_i);
            wait_cnt++;
         end
         if (alu_vld_o !== 1'b1) begin
            err_cnt++;
            $display("Row %0d: alu_vld_o never rose after the read request", idx);
         end else begin
            check_val("alu_vld_o latency", VLD_LAT, wait_cnt);
            check_val("vs1_data_o", r.exp1, vs1_data_o);
            check_val("vs2_data_o", r.exp2, vs2_data_o);
            check_val("alu_sew_o", {30'h0, r.sew}, {30'h0, alu_sew_o});
            check_val("alu_opmode_o", {26'h0, r.op}, {26'h0, alu_opmode_o});
            // ALU model adds the operands and answers one cycle later
            alu_sum = vs1_data_o + vs2_data_o;
            wait_drive_slot();
            drive_write_fields(r);
            alu_vld_i = 1'b1;
            alu_res_i = alu_sum;
            wb_src_i  = vl_pkg::WB_ALU;
            wait_drive_slot();
            clear_inputs();
         end
      end else begin
         drive_write_fields(r);
         alu_vld_i   = (r.kind == K_ALU);
         load_req_i  = (r.kind == K_LOAD);
         wb_src_i    = (r.kind == K_ALU) ? vl_pkg::WB_ALU : vl_pkg::WB_LOAD;
         alu_res_i   = r.data;
         load_data_i = r.data;
         wait_drive_slot();
         clear_inputs();
      end
      repeat (IDLE_GAP) @(posedge clk_i);
   endtask

   initial begin
      seed    = 32'h87d0;
      err_cnt = 0;
      rst_i   = 1'b0;
      clear_inputs();
      build_table();
      repeat (RST_CYCLES) begin
         wait_drive_slot();
         check_val("alu_vld_o", 32'h0, {31'h0, alu_vld_o});
      end
      rst_i = 1'b1;
      repeat (2) begin
         @(negedge clk_i);
         check_val("alu_vld_o", 32'h0, {31'h0, alu_vld_o});
      end
      foreach (rows[i]) begin
         apply_row(rows[i], i);
      end
      $display("Error count: %0d", err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      int limit_ns;
      #1;
      limit_ns = 2 * (rows.size() * ROW_CYCLES * CLK_PERIOD + RST_CYCLES * CLK_PERIOD);
      #(limit_ns);
      $display("Timeout: the run was still going after %0d ns", limit_ns);
      $display("Finished with errors");
      $finish;
   end

endmodule

/* compile.f */
+incdir+src
src/vl_pkg.sv
src/vl_vrf_if.sv
src/vl_vrf.sv
src/vl_operand_prep.sv
src/vl_writeback.sv
src/vl_lane_top.sv
sim/vl_lane_tb.sv

/* Bender.yml */
package:
  name: vl_lane

export_include_dirs:
  - src

sources:
  - files:
      - src/vl_pkg.sv
      - src/vl_vrf_if.sv
      - src/vl_vrf.sv
      - src/vl_operand_prep.sv
      - src/vl_writeback.sv
      - src/vl_lane_top.sv
  - target: test
    files:
      - sim/vl_lane_tb.sv
